/* Bender.yml */
package:
  name: softmax_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/softmax_pkg.sv
      - verilog/fx_exp_lut.sv
      - verilog/exp_buffer.sv
      - verilog/fx_divider.sv
      - verilog/softmax_norm.sv
      - verilog/softmax_top.sv

  - target: test
    files:
      - bench/softmax_props.sv
      - bench/softmax_tb.sv

/* bench/softmax_props.sv */
`timescale 1ns/1ps

module softmax_props (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     out_valid,
    input logic                     out_ready,
    input softmax_pkg::prob_s       out_data,
    input logic                     push,
    input logic                     full,
    input softmax_pkg::norm_state_e norm_state
);

    int fail_count = 0;

    // Stalled result holds
    a_out_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else begin
        $error("out_data changed while stalled");
        fail_count++;
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(push && full)
    ) else begin
        $error("push into a full exp buffer");
        fail_count++;
    end

    a_reset_quiet: assert property (
        @(posedge clk) !rst_n |-> !out_valid
    ) else begin
        $error("out_valid high during reset");
        fail_count++;
    end

    // Full buffer while still accumulating means an over-long vector
    a_vec_len: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(norm_state == softmax_pkg::ACCUM && full)
    ) else begin
        $error("vector longer than the exp buffer");
        fail_count++;
    end

endmodule

bind softmax_top softmax_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .push       (push),
    .full       (full),
    .norm_state (u_norm.state)
);

/* bench/softmax_stim.txt */
# V <vector id> | S <score, Q4.12 hex> <last> | E <probability, Q0.16 hex> <last>
# Probability is floor(exp * 65536 / sum) saturated to ffff, exp from the two tables
V 1
S 1000 1
E ffff 1
V 2
S 1000 0
S 0000 0
S f000 1
E aa4d 0
E 3ea6 0
E 170c 1
# Range extremes, clamp limits of Q4.12
V 3
S 7fff 0
S 8000 1
E ffff 0
E 0000 1
V 4
S 7000 0
S 8000 1
E ffff 0
E 0000 1
# Full buffer
V 5
S 0000 0
S 0000 0
S 0000 0
S 0000 0
S 0000 0
S 0000 0
S 0000 0
S 0000 1
E 2000 0
E 2000 0
E 2000 0
E 2000 0
E 2000 0
E 2000 0
E 2000 0
E 2000 1
V 6
S 0800 0
S f800 0
S 0000 0
S 2000 1
E 27a7 0
E 0e96 0
E 180c 0
E b1b5 1
V 7
S d000 0
S 3000 1
E 00a2 0
E ff5d 1

/* bench/softmax_tb.sv */
`timescale 1ns/1ps

module softmax_tb;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                in_valid;
    logic                in_ready;
    softmax_pkg::score_s in_data;
    logic                out_valid;
    logic                out_ready;
    softmax_pkg::prob_s  out_data;

    softmax_pkg::score_s scores[$];
    softmax_pkg::prob_s  expected[$];
    int                  vec_ids[$];
    int                  vec_len[$];   // Outputs per vector
    logic                loaded = 1'b0;
    logic                started = 1'b0;
    logic [31:0]         rng = 32'd1129;
    int                  n_scores = 0;
    int                  n_expected = 0;
    int                  errors = 0;
    int                  checks = 0;
    int                  out_count = 0;
    int                  vec_idx = 0;
    int                  vec_seen = 0;
    int                  vec_err_base = 0;
    int                  fd;

    softmax_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %s at %0t: got %0h, expected %0h", name, $time, got, want);
        end
    endtask

    task automatic read_stim(input int fh);
        string               op;
        string               rest;
        logic [31:0]         a;
        logic [31:0]         b;
        int                  r;
        softmax_pkg::score_s sc;
        softmax_pkg::prob_s  pr;
        while ($fscanf(fh, "%s", op) == 1) begin
            if (op == "V") begin
                r = $fscanf(fh, "%h", a);
                vec_ids.push_back(a);
                vec_len.push_back(0);
            end else if (op == "S") begin
                r = $fscanf(fh, "%h %h", a, b);
                sc.score = a[15:0];
                sc.last  = b[0];
                scores.push_back(sc);
            end else if (op == "E") begin
                r = $fscanf(fh, "%h %h", a, b);
                pr.prob = a[15:0];
                pr.last = b[0];
                expected.push_back(pr);
                vec_len[vec_len.size()-1] = vec_len[vec_len.size()-1] + 1;
            end else begin
                r = $fgets(rest, fh);  // Comment line
            end
        end
        $fclose(fh);
        n_scores   = scores.size();
        n_expected = expected.size();
    endtask

    // Scores go in without gaps, in_ready alone throttles them
    task automatic drive_scores();
        int idx;
        idx = 0;
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= scores[0];
        while (idx < n_scores) begin
            @(posedge clk);
            if (in_ready) begin
                idx++;
                if (idx < n_scores)
                    in_data <= scores[idx];
                else
                    in_valid <= 1'b0;
            end
        end
    endtask

    task automatic take_output();
        if (out_count >= n_expected) begin
            errors++;
            $display("Extra output at %0t beyond the %0d expected", $time, n_expected);
        end else begin
            check_value("out_data.prob", out_data.prob, expected[out_count].prob);
            check_value("out_data.last", out_data.last, expected[out_count].last);
            out_count++;
            vec_seen++;
            if (vec_seen == vec_len[vec_idx]) begin
                $display("vector %0d done: %0d outputs, %0d errors",
                         vec_ids[vec_idx], vec_seen, errors - vec_err_base);
                vec_idx++;
                vec_seen     = 0;
                vec_err_base = errors;
            end
        end
    endtask

    // Random back-pressure on the output
    always @(posedge clk) begin
        if (rst_n) begin
            rng = xorshift(rng);
            out_ready <= (rng[1:0] != 2'b00);
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (out_valid && !started) begin
                errors++;
                $display("out_valid went high at %0t before any input was accepted", $time);
            end
            if (in_valid && in_ready)
                started = 1'b1;
            if (out_valid && out_ready)
                take_output();
        end
    end

    initial begin
        wait (loaded);
        repeat (40 * n_scores + 200) @(posedge clk);
        $display("Timeout: only %0d of %0d results arrived", out_count, n_expected);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        fd = $fopen("bench/softmax_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/softmax_stim.txt");
            $display("TEST FAIL");
            $finish;
        end else begin
            read_stim(fd);
            loaded = 1'b1;
            repeat (10) @(posedge clk);
            rst_n <= 1'b1;
            repeat (5) @(posedge clk);  // Idle, out_valid stays low
            drive_scores();
            wait (out_count == n_expected);
            repeat (40) @(posedge clk);
            $display("vectors %0d/%0d, outputs %0d, checks %0d, errors %0d, assert fails %0d",
                     vec_idx, vec_ids.size(), out_count, checks, errors,
                     UUT.u_props.fail_count);
            if (errors == 0 && UUT.u_props.fail_count == 0)
                $display("TEST PASS");
            else
                $display("TEST FAIL");
            $finish;
        end
    end

endmodule

/* project.f */
+incdir+verilog
verilog/softmax_pkg.sv
verilog/fx_exp_lut.sv
verilog/exp_buffer.sv
verilog/fx_divider.sv
verilog/softmax_norm.sv
verilog/softmax_top.sv
bench/softmax_props.sv
bench/softmax_tb.sv

/* verilog/exp_buffer.sv */
`timescale 1ns/1ps
`include "softmax_defs.svh"

module exp_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  softmax_pkg::exp_s push_data,
    input  logic              pop,
    output softmax_pkg::exp_s head,
    output logic              full,
    output logic              empty
);

    localparam int DEPTH = `SM_VEC_MAX;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    softmax_pkg::exp_s mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     count;
    logic              do_push;
    logic              do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == CW'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

/* verilog/fx_divider.sv */
`timescale 1ns/1ps
`include "softmax_defs.svh"

module fx_divider (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  softmax_pkg::exp_t  dividend,
    input  softmax_pkg::sum_t  divisor,
    output logic               done,
    output softmax_pkg::prob_t quotient
);

    localparam int QBITS = `SM_EXP_FRAC + 1;  // One guard bit for 1.0
    localparam int CW    = $clog2(QBITS + 1);

    logic [CW-1:0]            cnt;
    logic [`SM_EXP_WIDTH-1:0] rem;
    logic [QBITS-1:0]         q;
    logic [`SM_EXP_WIDTH:0]   trial;
    logic [`SM_EXP_WIDTH:0]   diff;
    logic                     fits;
    logic                     idle;
    logic                     step_en;
    logic                     last_cyc;

    assign idle     = (cnt == '0);
    assign last_cyc = (cnt == CW'(1));
    assign step_en  = idle ? start : !last_cyc;

    // First quotient bit is taken on the load edge, from the dividend itself
    assign trial = idle ? {1'b0, dividend} : {rem, 1'b0};
    assign diff  = trial - {1'b0, divisor};
    assign fits  = (trial >= {1'b0, divisor});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (idle) begin
                if (start)
                    cnt <= CW'(QBITS);
            end else begin
                if (last_cyc)
                    done <= 1'b1;
                cnt <= cnt - 1'b1;
            end
        end
    end

    // 17 shifts in total, so stale q bits all fall out
    always_ff @(posedge clk) begin
        if (step_en) begin
            rem <= fits ? diff[`SM_EXP_WIDTH-1:0] : trial[`SM_EXP_WIDTH-1:0];
            q   <= {q[QBITS-2:0], fits};
        end
        if (last_cyc)
            quotient <= q[QBITS-1] ? '1 : q[QBITS-2:0];  // Saturate 1.0
    end

endmodule

/* verilog/fx_exp_lut.sv */
`timescale 1ns/1ps
`include "softmax_defs.svh"

module fx_exp_lut (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  softmax_pkg::score_s in_data,
    output logic                exp_valid,
    input  logic                exp_ready,
    output softmax_pkg::exp_s   exp_data
);

    localparam int CLAMP_LIM = 8 << `SM_FX_FRAC;

    softmax_pkg::fx_t  score_c;
    logic [3:0]        k_idx;   // Signed integer part, -8..7
    logic [3:0]        f_idx;
    logic [26:0]       int_val;
    logic [17:0]       frac_val;
    logic [47:0]       product;
    softmax_pkg::exp_t exp_val;
    logic              v_reg;
    softmax_pkg::exp_s data_reg;

    // Clamp to -8.0 .. just under +8.0
    always_comb begin
        if (int'(in_data.score) < -CLAMP_LIM)
            score_c = softmax_pkg::fx_t'(-CLAMP_LIM);
        else if (int'(in_data.score) > CLAMP_LIM - 1)
            score_c = softmax_pkg::fx_t'(CLAMP_LIM - 1);
        else
            score_c = in_data.score;
    end

    assign k_idx = 4'(score_c >>> `SM_FX_FRAC);  // Floor
    assign f_idx = score_c[`SM_FX_FRAC-1 -: 4];

    // e^k in Q16.16
    always_comb begin
        case (k_idx)
            4'h8:    int_val = 27'd22;
            4'h9:    int_val = 27'd60;
            4'hA:    int_val = 27'd162;
            4'hB:    int_val = 27'd442;
            4'hC:    int_val = 27'd1200;
            4'hD:    int_val = 27'd3263;
            4'hE:    int_val = 27'd8869;
            4'hF:    int_val = 27'd24109;   // e^-1
            4'h0:    int_val = 27'd65536;
            4'h1:    int_val = 27'd178145;
            4'h2:    int_val = 27'd484249;
            4'h3:    int_val = 27'd1316326;
            4'h4:    int_val = 27'd3578144;
            4'h5:    int_val = 27'd9726405;
            4'h6:    int_val = 27'd26439109;
            default: int_val = 27'd71868951;  // e^7
        endcase
    end

    // e^(f/16) in Q16.16
    always_comb begin
        case (f_idx)
            4'd0:    frac_val = 18'd65536;
            4'd1:    frac_val = 18'd69763;
            4'd2:    frac_val = 18'd74262;
            4'd3:    frac_val = 18'd79052;
            4'd4:    frac_val = 18'd84150;
            4'd5:    frac_val = 18'd89577;
            4'd6:    frac_val = 18'd95354;
            4'd7:    frac_val = 18'd101504;
            4'd8:    frac_val = 18'd108051;
            4'd9:    frac_val = 18'd115019;
            4'd10:   frac_val = 18'd122437;
            4'd11:   frac_val = 18'd130334;
            4'd12:   frac_val = 18'd138740;
            4'd13:   frac_val = 18'd147688;
            4'd14:   frac_val = 18'd157213;
            default: frac_val = 18'd167352;
        endcase
    end

    assign product = 48'(int_val) * 48'(frac_val);
    assign exp_val = product[`SM_EXP_FRAC +: `SM_EXP_WIDTH];  // Truncate

    // Output register, refills whenever downstream takes it
    assign in_ready = !v_reg || exp_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            v_reg <= 1'b0;
        else if (in_ready)
            v_reg <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            data_reg <= '{value: exp_val, last: in_data.last};
    end

    assign exp_valid = v_reg;
    assign exp_data  = data_reg;

endmodule

/* verilog/softmax_defs.svh */
`ifndef SOFTMAX_DEFS_SVH
`define SOFTMAX_DEFS_SVH

// Input scores, signed Q4.12
`define SM_FX_WIDTH   16
`define SM_FX_FRAC    12

// Exp values in Q16.16
`define SM_EXP_WIDTH  32
`define SM_EXP_FRAC   16

// Probabilities in Q0.16
`define SM_PROB_WIDTH 16

// Longest vector, also the buffer depth
`define SM_VEC_MAX    8

`endif

/* verilog/softmax_norm.sv */
`timescale 1ns/1ps

module softmax_norm (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               exp_valid,
    output logic               exp_ready,
    input  softmax_pkg::exp_s  exp_data,
    output logic               push,
    output softmax_pkg::exp_s  push_data,
    output logic               pop,
    input  softmax_pkg::exp_s  head,
    input  logic               full,
    input  logic               empty,
    output logic               div_start,
    output softmax_pkg::exp_t  div_dividend,
    output softmax_pkg::sum_t  div_divisor,
    input  logic               div_done,
    input  softmax_pkg::prob_t div_quotient,
    output logic               out_valid,
    input  logic               out_ready,
    output softmax_pkg::prob_s out_data
);

    softmax_pkg::norm_state_e state;
    softmax_pkg::sum_t        sum;
    logic                     accept;
    logic                     out_fire;

    assign exp_ready = (state == softmax_pkg::ACCUM) && !full;
    assign accept    = exp_valid && exp_ready;
    assign out_fire  = out_valid && out_ready;

    // Every accepted exp goes into the buffer
    assign push      = accept;
    assign push_data = exp_data;
    assign pop       = out_fire;

    // Divide the head only once the previous result has left
    assign div_start    = (state == softmax_pkg::DRAIN) && !out_valid && !empty;
    assign div_dividend = head.value;
    assign div_divisor  = sum;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= softmax_pkg::ACCUM;
            sum   <= '0;
        end else begin
            case (state)
                softmax_pkg::ACCUM: begin
                    if (accept) begin
                        sum <= sum + exp_data.value;
                        if (exp_data.last)
                            state <= softmax_pkg::DRAIN;
                    end
                end
                softmax_pkg::WAIT_DIV: begin
                    if (div_done)
                        state <= softmax_pkg::DRAIN;
                end
                softmax_pkg::DRAIN: begin
                    if (div_start) begin
                        state <= softmax_pkg::WAIT_DIV;
                    end else if (out_fire && out_data.last) begin
                        state <= softmax_pkg::ACCUM;  // Vector done
                        sum   <= '0;
                    end
                end
                default: state <= softmax_pkg::ACCUM;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (div_done)
            out_valid <= 1'b1;
        else if (out_fire)
            out_valid <= 1'b0;
    end

    // Last flag rides along from the buffer head
    always_ff @(posedge clk) begin
        if (div_done)
            out_data <= '{prob: div_quotient, last: head.last};
    end

endmodule

/* verilog/softmax_pkg.sv */
`include "softmax_defs.svh"

package softmax_pkg;

    typedef logic signed [`SM_FX_WIDTH-1:0] fx_t;
    typedef logic [`SM_EXP_WIDTH-1:0]       exp_t;
    typedef logic [`SM_PROB_WIDTH-1:0]      prob_t;
    typedef logic [`SM_EXP_WIDTH-1:0]       sum_t;  // 8 x largest exp fits

    typedef struct packed {
        fx_t  score;
        logic last;
    } score_s;

    typedef struct packed {
        exp_t value;
        logic last;
    } exp_s;

    typedef struct packed {
        prob_t prob;
        logic  last;
    } prob_s;

    typedef enum logic [1:0] {
        ACCUM,
        WAIT_DIV,
        DRAIN
    } norm_state_e;

endpackage

/* verilog/softmax_top.sv */
`timescale 1ns/1ps

module softmax_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  softmax_pkg::score_s in_data,
    output logic                out_valid,
    input  logic                out_ready,
    output softmax_pkg::prob_s  out_data
);

    logic               exp_valid;
    logic               exp_ready;
    softmax_pkg::exp_s  exp_data;
    logic               push;
    softmax_pkg::exp_s  push_data;
    logic               pop;
    softmax_pkg::exp_s  head;
    logic               full;
    logic               empty;
    logic               div_start;
    softmax_pkg::exp_t  div_dividend;
    softmax_pkg::sum_t  div_divisor;
    logic               div_done;
    softmax_pkg::prob_t div_quotient;

    fx_exp_lut u_exp (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .exp_valid (exp_valid),
        .exp_ready (exp_ready),
        .exp_data  (exp_data)
    );

    exp_buffer u_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .full      (full),
        .empty     (empty)
    );

    softmax_norm u_norm (
        .clk          (clk),
        .rst_n        (rst_n),
        .exp_valid    (exp_valid),
        .exp_ready    (exp_ready),
        .exp_data     (exp_data),
        .push         (push),
        .push_data    (push_data),
        .pop          (pop),
        .head         (head),
        .full         (full),
        .empty        (empty),
        .div_start    (div_start),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .div_done     (div_done),
        .div_quotient (div_quotient),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data)
    );

    fx_divider u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_start),
        .dividend (div_dividend),
        .divisor  (div_divisor),
        .done     (div_done),
        .quotient (div_quotient)
    );

endmodule
